// File: hdl/clk_rst_pkg.sv
`default_nettype none

package clk_rst_pkg;

  //////////////////////////////////////////////////////////////////////
  // Sizes
  //////////////////////////////////////////////////////////////////////

  localparam int MAX_CLOCKS = 8;
  localparam int DIV_WIDTH = 8;
  localparam int REG_ADDR_WIDTH = 4;
  localparam int REG_DATA_WIDTH = 32;

  typedef logic [REG_ADDR_WIDTH-1:0] reg_addr_t;
  typedef logic [REG_DATA_WIDTH-1:0] reg_data_t;
  typedef logic [DIV_WIDTH-1:0] division_t;

  //////////////////////////////////////////////////////////////////////
  // Register map
  //////////////////////////////////////////////////////////////////////

  // Clocks 0 to 3, clock 0 in the low byte
  localparam reg_addr_t ADDR_DIV_LO = 4'd0;
  // Clocks 4 to 7
  localparam reg_addr_t ADDR_DIV_HI = 4'd1;
  // Write-only pulse registers, one bit per clock
  localparam reg_addr_t ADDR_VALID = 4'd2;
  localparam reg_addr_t ADDR_RESET = 4'd3;

  typedef struct packed {
    logic      write;
    reg_addr_t addr;
    reg_data_t wdata;
  } reg_req_t;

  typedef struct packed {
    division_t [MAX_CLOCKS-1:0] division;
    logic [MAX_CLOCKS-1:0]      valid_pulse;
    logic [MAX_CLOCKS-1:0]      reset_pulse;
  } reg2hw_t;

endpackage

`default_nettype wire

// File: hdl/clk_rst_regs.sv
`timescale 1ns/1ps
`default_nettype none

module clk_rst_regs
  import clk_rst_pkg::*;
#(
  parameter int NumClocks = 4,
  parameter int DefaultDivision[NumClocks] = '{default: 1}
) (
  input  wire logic     control_clk_i,
  input  wire logic     control_rst_n_i,
  input  wire reg_req_t reg_req_i,
  output reg_data_t     reg_rdata_o,
  output reg2hw_t       reg2hw_o
);

  typedef division_t [MAX_CLOCKS-1:0] division_vec_t;

  localparam int DivsPerWord = REG_DATA_WIDTH / DIV_WIDTH;
  // Only the implemented clocks keep pulse bits
  localparam logic [MAX_CLOCKS-1:0] ClockMask = {MAX_CLOCKS{1'b1}} >> (MAX_CLOCKS - NumClocks);

  function automatic division_vec_t default_divisions();
    division_vec_t div;
    div = '0;
    for (int i = 0; i < NumClocks; i++) begin
      div[i] = division_t'(DefaultDivision[i]);
    end
    return div;
  endfunction

  division_vec_t         division_q;
  logic [MAX_CLOCKS-1:0] valid_q;
  logic [MAX_CLOCKS-1:0] reset_q;
  logic [1:0]            div_word_we;
  logic                  valid_we;
  logic                  reset_we;

  assign div_word_we[0] = reg_req_i.write && (reg_req_i.addr == ADDR_DIV_LO);
  assign div_word_we[1] = reg_req_i.write && (reg_req_i.addr == ADDR_DIV_HI);
  assign valid_we = reg_req_i.write && (reg_req_i.addr == ADDR_VALID);
  assign reset_we = reg_req_i.write && (reg_req_i.addr == ADDR_RESET);

  always_ff @(posedge control_clk_i or negedge control_rst_n_i) begin
    if (!control_rst_n_i) begin
      division_q <= default_divisions();
      valid_q <= '0;
      reset_q <= '0;
    end else begin
      // Unused clocks are never written and stay at zero
      for (int i = 0; i < NumClocks; i++) begin
        if (div_word_we[i / DivsPerWord]) begin
          division_q[i] <= reg_req_i.wdata[(i % DivsPerWord) * DIV_WIDTH +: DIV_WIDTH];
        end
      end
      // Pulse bits clear on the next edge
      valid_q <= valid_we ? (reg_req_i.wdata[MAX_CLOCKS-1:0] & ClockMask) : '0;
      reset_q <= reset_we ? (reg_req_i.wdata[MAX_CLOCKS-1:0] & ClockMask) : '0;
    end
  end

  // Pulse registers read back as zero
  always_comb begin
    case (reg_req_i.addr)
      ADDR_DIV_LO: reg_rdata_o = division_q[DivsPerWord-1:0];
      ADDR_DIV_HI: reg_rdata_o = division_q[MAX_CLOCKS-1:DivsPerWord];
      default:     reg_rdata_o = '0;
    endcase
  end

  assign reg2hw_o = '{division: division_q, valid_pulse: valid_q, reset_pulse: reset_q};

  // Bus master must stay inside the four mapped words
  wr_addr_in_map: assert property (
    @(posedge control_clk_i) disable iff (!control_rst_n_i)
    reg_req_i.write |-> (reg_req_i.addr <= ADDR_RESET)
  ) else $error("Write to unmapped address %0d", reg_req_i.addr);

endmodule

`default_nettype wire

// File: hdl/mst_domain_sync.sv
`timescale 1ns/1ps
`default_nettype none

module mst_domain_sync #(
  parameter int NumClocks = 4
) (
  input  wire logic                 mst_clk_i,
  input  wire logic                 control_rst_n_i,
  input  wire logic [NumClocks-1:0] valid_pulse_i,
  output logic                      control_rst_n_d2_mst_clk_o,
  output logic [NumClocks-1:0]      div_valid_o
);

  //////////////////////////////////////////////////////////////////////
  // Reset synchronizer
  //////////////////////////////////////////////////////////////////////

  logic control_rst_n_d1_mst_clk;
  logic control_rst_n_d2_mst_clk;

  // Asserts at once, releases after two mst edges
  always_ff @(posedge mst_clk_i or negedge control_rst_n_i) begin
    if (!control_rst_n_i) begin
      control_rst_n_d1_mst_clk <= 1'b0;
      control_rst_n_d2_mst_clk <= 1'b0;
    end else begin
      control_rst_n_d1_mst_clk <= 1'b1;
      control_rst_n_d2_mst_clk <= control_rst_n_d1_mst_clk;
    end
  end

  assign control_rst_n_d2_mst_clk_o = control_rst_n_d2_mst_clk;

  // Divisor valid bits, control clock must be at least 3x slower
  logic [NumClocks-1:0] valid_d1;
  logic [NumClocks-1:0] valid_d2;

  always_ff @(posedge mst_clk_i or negedge control_rst_n_d2_mst_clk) begin
    if (!control_rst_n_d2_mst_clk) begin
      valid_d1 <= '0;
      valid_d2 <= '0;
    end else begin
      valid_d1 <= valid_pulse_i;
      valid_d2 <= valid_d1;
    end
  end

  assign div_valid_o = valid_d2;

endmodule

`default_nettype wire

// File: hdl/clock_divider.sv
`timescale 1ns/1ps
`default_nettype none

module clock_divider
  import clk_rst_pkg::*;
#(
  parameter int DefaultDivision = 1
) (
  input  wire logic      mst_clk_i,
  input  wire logic      control_rst_n_d2_mst_clk,
  input  wire logic      test_mode_i,
  input  wire division_t divisor_i,
  input  wire logic      divisor_valid_i,
  output logic           clk_o
);

  division_t div_q;
  division_t cnt_q;
  division_t cnt_next;
  division_t high_start;
  logic      clk_q;
  logic      div_bypass;
  logic      bypass;

  // Division of 0 or 1 passes the master clock through
  assign div_bypass = (div_q < division_t'(2));
  assign bypass = test_mode_i || div_bypass;

  // Output is high for the last floor(N/2) counts
  assign high_start = div_q - (div_q >> 1);
  assign cnt_next = (cnt_q >= div_q - division_t'(1)) ? '0 : cnt_q + division_t'(1);

  //////////////////////////////////////////////////////////////////////
  // Counter and output flop
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge mst_clk_i or negedge control_rst_n_d2_mst_clk) begin
    if (!control_rst_n_d2_mst_clk) begin
      div_q <= division_t'(DefaultDivision);
      cnt_q <= '0;
      clk_q <= 1'b0;
    end else if (divisor_valid_i) begin
      // New value restarts the count with the output low
      div_q <= divisor_i;
      cnt_q <= '0;
      clk_q <= 1'b0;
    end else if (div_bypass) begin
      cnt_q <= '0;
      clk_q <= 1'b0;
    end else begin
      cnt_q <= cnt_next;
      clk_q <= (cnt_next >= high_start);
    end
  end

  // Plain mux, test mode overrides without a clock edge
  assign clk_o = bypass ? mst_clk_i : clk_q;

  // Holds across loads of a new divisor as well
  cnt_below_div: assert property (
    @(posedge mst_clk_i) disable iff (!control_rst_n_d2_mst_clk)
    (div_q >= division_t'(2)) |-> (cnt_q < div_q)
  ) else $error("Divider count %0d not below divisor %0d", cnt_q, div_q);

endmodule

`default_nettype wire

// File: hdl/reset_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

module reset_sequencer #(
  parameter int ResetDelay = 1
) (
  input  wire logic clk_i,
  input  wire logic async_global_rst_n_i,
  input  wire logic async_local_rst_n_i,
  output logic      rst_n_o
);

  logic                  async_rst_n;
  logic [ResetDelay-1:0] rst_chain_q;

  // Either source clears the chain immediately
  assign async_rst_n = async_global_rst_n_i & async_local_rst_n_i;

  // Ones shift in on each divided clock edge
  always_ff @(posedge clk_i or negedge async_rst_n) begin
    if (!async_rst_n) begin
      rst_chain_q <= '0;
    end else begin
      rst_chain_q <= (rst_chain_q << 1) | 1'b1;
    end
  end

  // Released on the ResetDelay-th edge after both inputs go high
  assign rst_n_o = rst_chain_q[ResetDelay-1];

  // A local reset pulse from the register block always reaches the output
  local_rst_holds_output: assert property (
    @(posedge clk_i)
    !async_local_rst_n_i |-> !rst_n_o
  ) else $error("rst_n_o high during local reset");

endmodule

`default_nettype wire

// File: hdl/clk_rst_controller.sv
`timescale 1ns/1ps
`default_nettype none

module clk_rst_controller
  import clk_rst_pkg::*;
#(
  parameter int NumClocks = 4,
  parameter int DefaultDivision[NumClocks] = '{default: 1},
  parameter int ResetDelays[NumClocks] = '{default: 1}
) (
  input  wire logic            test_mode_i,
  input  wire logic            control_clk_i,
  input  wire logic            control_rst_n_i,
  input  wire reg_req_t        reg_req_i,
  output reg_data_t            reg_rdata_o,
  input  wire logic            mst_clk_i,
  input  wire logic            mst_rst_n_i,
  output logic [NumClocks-1:0] clk_o,
  output logic [NumClocks-1:0] rst_n_o
);

  if (NumClocks < 1 || NumClocks > MAX_CLOCKS) begin : gen_bad_num_clocks
    $error("NumClocks must be between 1 and %0d", MAX_CLOCKS);
  end

  reg2hw_t              reg2hw;
  logic                 control_rst_n_d2_mst_clk;
  logic [NumClocks-1:0] div_valid;
  logic [NumClocks-1:0] local_rst_n;

  //////////////////////////////////////////////////////////////////////
  // Control domain
  //////////////////////////////////////////////////////////////////////

  clk_rst_regs #(
    .NumClocks       (NumClocks),
    .DefaultDivision (DefaultDivision)
  ) i_clk_rst_regs (
    .control_clk_i   (control_clk_i),
    .control_rst_n_i (control_rst_n_i),
    .reg_req_i       (reg_req_i),
    .reg_rdata_o     (reg_rdata_o),
    .reg2hw_o        (reg2hw)
  );

  mst_domain_sync #(
    .NumClocks (NumClocks)
  ) i_mst_domain_sync (
    .mst_clk_i                  (mst_clk_i),
    .control_rst_n_i            (control_rst_n_i),
    .valid_pulse_i              (reg2hw.valid_pulse[NumClocks-1:0]),
    .control_rst_n_d2_mst_clk_o (control_rst_n_d2_mst_clk),
    .div_valid_o                (div_valid)
  );

  // Reset pulse bits are active high
  assign local_rst_n = ~reg2hw.reset_pulse[NumClocks-1:0];

  //////////////////////////////////////////////////////////////////////
  // Per-clock dividers and reset sequencers
  //////////////////////////////////////////////////////////////////////

  for (genvar i = 0; i < NumClocks; i++) begin : gen_clock
    clock_divider #(
      .DefaultDivision (DefaultDivision[i])
    ) i_clock_divider (
      .mst_clk_i                (mst_clk_i),
      .control_rst_n_d2_mst_clk (control_rst_n_d2_mst_clk),
      .test_mode_i              (test_mode_i),
      .divisor_i                (reg2hw.division[i]),
      .divisor_valid_i          (div_valid[i]),
      .clk_o                    (clk_o[i])
    );

    reset_sequencer #(
      .ResetDelay (ResetDelays[i])
    ) i_reset_sequencer (
      .clk_i                (clk_o[i]),
      .async_global_rst_n_i (mst_rst_n_i),
      .async_local_rst_n_i  (local_rst_n[i]),
      .rst_n_o              (rst_n_o[i])
    );
  end

endmodule

`default_nettype wire

// File: testbench/tb_clk_rst_controller.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clk_rst_controller
  import clk_rst_pkg::*;
;

  localparam int NUM_CLOCKS = 4;
  localparam int DEF_DIV[NUM_CLOCKS] = '{1, 2, 3, 4};
  localparam int RST_DELAYS[NUM_CLOCKS] = '{1, 2, 3, 4};
  localparam int MST_PERIOD = 100;
  localparam int CTRL_PERIOD = 400;
  // Control-cycle budget of each test in run order
  localparam int TEST_CTRL_CYCLES = 5 + 20 + 20 + 80 + 25 + 25 + 70;
  localparam int WATCHDOG_NS = 2 * TEST_CTRL_CYCLES * CTRL_PERIOD;

  logic                  mst_clk_i;
  logic                  control_clk_i;
  logic                  control_rst_n_i;
  logic                  mst_rst_n_i;
  logic                  test_mode_i;
  reg_req_t              reg_req_i;
  reg_data_t             reg_rdata_o;
  logic [NUM_CLOCKS-1:0] clk_o;
  logic [NUM_CLOCKS-1:0] rst_n_o;

  int error_count;
  int exp_div[NUM_CLOCKS];

  clk_rst_controller #(
    .NumClocks       (NUM_CLOCKS),
    .DefaultDivision (DEF_DIV),
    .ResetDelays     (RST_DELAYS)
  ) i_clk_rst_controller (
    .test_mode_i     (test_mode_i),
    .control_clk_i   (control_clk_i),
    .control_rst_n_i (control_rst_n_i),
    .reg_req_i       (reg_req_i),
    .reg_rdata_o     (reg_rdata_o),
    .mst_clk_i       (mst_clk_i),
    .mst_rst_n_i     (mst_rst_n_i),
    .clk_o           (clk_o),
    .rst_n_o         (rst_n_o)
  );

  always #(MST_PERIOD / 2) mst_clk_i = ~mst_clk_i;
  // Control edges fall on mst falling edges
  always #(CTRL_PERIOD / 2) control_clk_i = ~control_clk_i;

  //////////////////////////////////////////////////////////////////////
  // Compare tasks
  //////////////////////////////////////////////////////////////////////

  task automatic check_word(input string name, input reg_data_t exp, input reg_data_t act);
    if (exp !== act) begin
      error_count++;
      $display("Fail at %0t: %s expected %h, got %h", $time, name, exp, act);
    end
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    if (exp !== act) begin
      error_count++;
      $display("Fail at %0t: %s expected %b, got %b", $time, name, exp, act);
    end
  endtask

  task automatic check_period(input string name, input int exp, input int act);
    if (exp != act) begin
      error_count++;
      $display("Fail at %0t: %s expected %0d, got %0d", $time, name, exp, act);
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // Bus and clock helpers
  //////////////////////////////////////////////////////////////////////

  task automatic write_reg(input reg_addr_t addr, input reg_data_t data);
    @(posedge control_clk_i);
    reg_req_i.write <= 1'b1;
    reg_req_i.addr <= addr;
    reg_req_i.wdata <= data;
    @(posedge control_clk_i);
    reg_req_i.write <= 1'b0;
  endtask

  // Combinational read data is sampled half a control cycle later
  task automatic read_reg(input reg_addr_t addr, output reg_data_t data);
    @(posedge control_clk_i);
    reg_req_i.write <= 1'b0;
    reg_req_i.addr <= addr;
    @(negedge control_clk_i);
    data = reg_rdata_o;
  endtask

  task automatic wait_clk_rise(input int idx);
    case (idx)
      0: @(posedge clk_o[0]);
      1: @(posedge clk_o[1]);
      2: @(posedge clk_o[2]);
      default: @(posedge clk_o[3]);
    endcase
  endtask

  task automatic measure_period(input int idx, output int cycles);
    time t_first;
    time t_second;
    wait_clk_rise(idx);
    t_first = $time;
    wait_clk_rise(idx);
    t_second = $time;
    cycles = int'((t_second - t_first) / MST_PERIOD);
  endtask

  // Divisions 0 and 1 bypass to a period of one mst cycle
  function automatic int expected_period(input int div);
    return (div < 2) ? 1 : div;
  endfunction

  function automatic reg_data_t pack_divisions();
    reg_data_t word;
    word = '0;
    for (int i = 0; i < NUM_CLOCKS; i++) begin
      word[i*8 +: 8] = exp_div[i][7:0];
    end
    return word;
  endfunction

  task automatic verify_periods(input bit all_bypass);
    int cycles;
    for (int i = 0; i < NUM_CLOCKS; i++) begin
      @(negedge mst_clk_i);
      measure_period(i, cycles);
      check_period($sformatf("clk_o[%0d] period", i),
                   all_bypass ? 1 : expected_period(exp_div[i]), cycles);
    end
  endtask

  task automatic check_all_resets(input logic exp);
    for (int i = 0; i < NUM_CLOCKS; i++) begin
      check_bit($sformatf("rst_n_o[%0d]", i), exp, rst_n_o[i]);
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // Directed tests
  //////////////////////////////////////////////////////////////////////

  task automatic reset_defaults();
    reg_data_t data;
    read_reg(ADDR_DIV_LO, data);
    check_word("reg_rdata_o DIV_LO", pack_divisions(), data);
    read_reg(ADDR_DIV_HI, data);
    check_word("reg_rdata_o DIV_HI", '0, data);
    read_reg(ADDR_VALID, data);
    check_word("reg_rdata_o VALID", '0, data);
    read_reg(ADDR_RESET, data);
    check_word("reg_rdata_o RESET", '0, data);
    // Longest release is 4 edges of a divide-by-4 clock
    repeat (8) @(negedge control_clk_i);
    check_all_resets(1'b1);
  endtask

  task automatic default_periods();
    verify_periods(1'b0);
  endtask

  task automatic program_divisors();
    reg_data_t data;
    int        new_div[NUM_CLOCKS];
    for (int i = 0; i < NUM_CLOCKS; i++) begin
      new_div[i] = 2 + ($urandom % 8);
      exp_div[i] = new_div[i];
    end
    write_reg(ADDR_DIV_LO, pack_divisions());
    read_reg(ADDR_DIV_LO, data);
    check_word("reg_rdata_o DIV_LO", pack_divisions(), data);
    // No valid pulse yet, so the defaults still run
    for (int i = 0; i < NUM_CLOCKS; i++) begin
      exp_div[i] = DEF_DIV[i];
    end
    verify_periods(1'b0);
    for (int i = 0; i < NUM_CLOCKS; i++) begin
      exp_div[i] = new_div[i];
    end
    write_reg(ADDR_VALID, '1);
    repeat (3) @(posedge control_clk_i);
    verify_periods(1'b0);
  endtask

  task automatic local_reset();
    write_reg(ADDR_RESET, 32'h4);
    @(negedge control_clk_i);
    for (int i = 0; i < NUM_CLOCKS; i++) begin
      check_bit($sformatf("rst_n_o[%0d]", i), (i == 2) ? 1'b0 : 1'b1, rst_n_o[i]);
    end
    // Three edges of a clock divided by up to 9
    repeat (12) @(negedge control_clk_i);
    check_bit("rst_n_o[2]", 1'b1, rst_n_o[2]);
  endtask

  task automatic global_reset();
    @(posedge mst_clk_i);
    mst_rst_n_i <= 1'b0;
    repeat (3) @(negedge mst_clk_i);
    check_all_resets(1'b0);
    @(posedge mst_clk_i);
    mst_rst_n_i <= 1'b1;
    repeat (50) @(negedge mst_clk_i);
    check_all_resets(1'b1);
  endtask

  task automatic test_mode_bypass();
    @(posedge mst_clk_i);
    test_mode_i <= 1'b1;
    repeat (12) @(posedge mst_clk_i);
    verify_periods(1'b1);
    test_mode_i <= 1'b0;
    repeat (12) @(posedge mst_clk_i);
    verify_periods(1'b0);
  endtask

  //////////////////////////////////////////////////////////////////////
  // Main sequence and watchdog
  //////////////////////////////////////////////////////////////////////

  initial begin
    mst_clk_i = 1'b0;
    control_clk_i = 1'b0;
    control_rst_n_i = 1'b0;
    mst_rst_n_i = 1'b0;
    test_mode_i = 1'b0;
    reg_req_i = '0;
    error_count = 0;
    void'($urandom(22));
    for (int i = 0; i < NUM_CLOCKS; i++) begin
      exp_div[i] = DEF_DIV[i];
    end
    repeat (5) @(posedge control_clk_i);
    control_rst_n_i <= 1'b1;
    mst_rst_n_i <= 1'b1;
    reset_defaults();
    default_periods();
    program_divisors();
    local_reset();
    global_reset();
    test_mode_bypass();
    $display("Errors: %0d", error_count);
    if (error_count == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

  initial begin
    #(WATCHDOG_NS);
    $display("Timeout: the tests did not finish within %0d ns", WATCHDOG_NS);
    $display("TEST RESULT: FAIL");
    $finish;
  end

endmodule

`default_nettype wire

// File: project.f
hdl/clk_rst_pkg.sv
hdl/clk_rst_regs.sv
hdl/mst_domain_sync.sv
hdl/clock_divider.sv
hdl/reset_sequencer.sv
hdl/clk_rst_controller.sv
testbench/tb_clk_rst_controller.sv
